// ==== filelist.f ====
+incdir+verilog
verilog/axi_lite_pkg.sv
verilog/bank_mem_pkg.sv
verilog/bank_port_if.sv
verilog/axi_write_join.sv
verilog/bank_array.sv
verilog/axi_read_path.sv
verilog/axi_lite_bank_mem.sv
test/tb_axi_lite_bank_mem.sv

// ==== test/axi_stim.txt ====
# op addr data strb resp rdata order, all hex
# resp 0 OKAY 2 SLVERR, order 0 AW with W, 1 AW first, 2 W first
W 00000000 deadbeef f 0 00000000 0
W 00000114 01234567 f 0 00000000 1
W 000002fc 89abcdef f 0 00000000 2
W 00000328 0badf00d f 0 00000000 0
W 00000404 55aa33cc f 0 00000000 2
W 00000584 7e57da7a f 0 00000000 1
R 00000000 00000000 0 0 deadbeef 0
R 00000114 00000000 0 0 01234567 0
R 000002fc 00000000 0 0 89abcdef 0
R 00000328 00000000 0 0 0badf00d 0
R 00000404 00000000 0 0 55aa33cc 0
R 00000584 00000000 0 0 7e57da7a 0
# partial strobes, rdata is the merged word
W 00000114 aabbccdd 5 0 00000000 2
R 00000114 00000000 0 0 01bb45dd 0
W 00000584 11223344 a 0 00000000 1
R 00000584 00000000 0 0 1157337a 0
W 000002fc ffeeddcc 8 0 00000000 0
R 000002fc 00000000 0 0 ffabcdef 0
W 00000404 00000099 1 0 00000000 2
R 00000404 00000000 0 0 55aa3399 0
# banks 6 and 7 are not backed by memory
W 00000614 cafef00d f 2 00000000 1
R 00000614 00000000 0 2 00000000 0
W 00000700 12345678 f 2 00000000 2
R 00000700 00000000 0 2 00000000 0
R 000007fc 00000000 0 2 00000000 0
R 00000114 00000000 0 0 01bb45dd 0
R 00000000 00000000 0 0 deadbeef 0
W 00000328 a5a5a5a5 f 0 00000000 2
R 00000328 00000000 0 0 a5a5a5a5 0

// ==== test/tb_axi_lite_bank_mem.sv ====
// ========================================
// testbench for the AXI4-Lite bank memory
// replays test/axi_stim.txt with random
// B and R stalls and checks the responses
// ========================================
`timescale 1ns/1ns

module tb_axi_lite_bank_mem;

  localparam int MAX_LINES = 64;

  logic                    clk;
  logic                    rst_n;
  logic                    aw_valid;
  logic                    aw_ready;
  axi_lite_pkg::axi_addr_t aw_addr;
  logic                    w_valid;
  logic                    w_ready;
  axi_lite_pkg::axi_data_t w_data;
  axi_lite_pkg::axi_strb_t w_strb;
  logic                    b_valid;
  logic                    b_ready;
  axi_lite_pkg::axi_resp_t b_resp;
  logic                    ar_valid;
  logic                    ar_ready;
  axi_lite_pkg::axi_addr_t ar_addr;
  logic                    r_valid;
  logic                    r_ready;
  axi_lite_pkg::axi_data_t r_data;
  axi_lite_pkg::axi_resp_t r_resp;

  // stim table, one entry per transaction line
  logic [7:0]  stim_op    [MAX_LINES];
  logic [31:0] stim_addr  [MAX_LINES];
  logic [31:0] stim_data  [MAX_LINES];
  logic [31:0] stim_strb  [MAX_LINES];
  logic [31:0] stim_resp  [MAX_LINES];
  logic [31:0] stim_rdata [MAX_LINES];
  logic [31:0] stim_order [MAX_LINES];
  int          n_lines;
  int          n_writes;
  int          n_reads;

  int          error_count;
  int          tests_passed;
  int          tests_failed;
  int          b_count;
  int          r_count;
  logic        b_free_q;
  logic        r_free_q;
  int          cycle_count;
  int          cycle_limit;
  logic [31:0] rng_state;

  axi_lite_bank_mem DUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .aw_addr  (aw_addr),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .w_data   (w_data),
    .w_strb   (w_strb),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .b_resp   (b_resp),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .ar_addr  (ar_addr),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .r_data   (r_data),
    .r_resp   (r_resp)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // ========================================
  // timeout and response monitor
  // ========================================
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("timeout: run still busy after %0d cycles", cycle_limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  // a response is new when its slot was free in the cycle before
  always @(negedge clk) begin
    #1;
    if (rst_n && b_valid && b_free_q) begin
      b_count = b_count + 1;
    end
    if (rst_n && r_valid && r_free_q) begin
      r_count = r_count + 1;
    end
    b_free_q = !b_valid || b_ready;
    r_free_q = !r_valid || r_ready;
  end

  // ========================================
  // helpers
  // ========================================
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // 0 to 7 cycles of ready held low
  task automatic draw_stall(output int stall);
    rng_state = lcg_next(rng_state);
    stall = int'(rng_state[18:16]);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("[FAIL] %s: got %h, expected %h at %0t ns", name, got, expected, $time);
      error_count = error_count + 1;
    end
  endtask

  task automatic report_test(input string what, input int errors_before);
    if (error_count == errors_before) begin
      tests_passed = tests_passed + 1;
      $display("test %0d %s: ok", tests_passed + tests_failed, what);
    end else begin
      tests_failed = tests_failed + 1;
      $display("test %0d %s: failed", tests_passed + tests_failed, what);
    end
  endtask

  task automatic load_stim();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [31:0] f [6];
    n_lines  = 0;
    n_writes = 0;
    n_reads  = 0;
    fd = $fopen("test/axi_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open test/axi_stim.txt");
    end else begin
      while (!$feof(fd) && n_lines < MAX_LINES) begin
        line = "";
        n = $fgets(line, fd);
        n = $sscanf(line, "%c %h %h %h %h %h %h", op, f[0], f[1], f[2], f[3], f[4], f[5]);
        // comment and blank lines fail to parse
        if (n == 7 && (op == "W" || op == "R")) begin
          stim_op[n_lines]    = op;
          stim_addr[n_lines]  = f[0];
          stim_data[n_lines]  = f[1];
          stim_strb[n_lines]  = f[2];
          stim_resp[n_lines]  = f[3];
          stim_rdata[n_lines] = f[4];
          stim_order[n_lines] = f[5];
          if (op == "W") begin
            n_writes = n_writes + 1;
          end else begin
            n_reads = n_reads + 1;
          end
          n_lines = n_lines + 1;
        end
      end
      $fclose(fd);
    end
  endtask

  // ========================================
  // AXI drivers
  // ========================================
  // called on a falling edge, returns on one
  task automatic run_write(input int idx);
    logic                    aw_done;
    logic                    w_done;
    logic                    aw_fire;
    logic                    w_fire;
    axi_lite_pkg::axi_resp_t resp_seen;
    int                      stall;
    aw_done = 1'b0;
    w_done  = 1'b0;
    aw_addr = stim_addr[idx];
    w_data  = stim_data[idx];
    w_strb  = stim_strb[idx][3:0];
    while (!(aw_done && w_done)) begin
      aw_valid = !aw_done && (stim_order[idx] != 2 || w_done);
      w_valid  = !w_done && (stim_order[idx] != 1 || aw_done);
      #1;
      // a held half keeps its ready low
      if (aw_done) begin
        check_value("aw_ready", aw_ready, 0);
      end
      if (w_done) begin
        check_value("w_ready", w_ready, 0);
      end
      aw_fire = aw_valid && aw_ready;
      w_fire  = w_valid && w_ready;
      check_value("b_valid", b_valid, 0);
      @(negedge clk);
      aw_done = aw_done | aw_fire;
      w_done  = w_done | w_fire;
    end
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    #1;
    // commit happens one edge after the later transfer
    check_value("b_valid", b_valid, 0);
    check_value("aw_ready", aw_ready, 0);
    check_value("w_ready", w_ready, 0);
    @(negedge clk);
    #1;
    check_value("b_valid", b_valid, 1);
    check_value("b_resp", b_resp, stim_resp[idx]);
    resp_seen = b_resp;
    draw_stall(stall);
    repeat (stall) begin
      @(negedge clk);
      #1;
      check_value("b_valid", b_valid, 1);
      check_value("b_resp", b_resp, resp_seen);
    end
    @(negedge clk);
    b_ready = 1'b1;
    #1;
    check_value("b_valid", b_valid, 1);
    @(negedge clk);
    b_ready = 1'b0;
    #1;
    check_value("b_valid", b_valid, 0);
    @(negedge clk);
  endtask

  task automatic run_read(input int idx);
    logic                    ar_fire;
    axi_lite_pkg::axi_data_t data_seen;
    axi_lite_pkg::axi_resp_t resp_seen;
    int                      stall;
    ar_fire = 1'b0;
    ar_addr = stim_addr[idx];
    while (!ar_fire) begin
      ar_valid = 1'b1;
      #1;
      ar_fire = ar_ready;
      check_value("r_valid", r_valid, 0);
      @(negedge clk);
    end
    ar_valid = 1'b0;
    #1;
    // r_valid comes up at the AR transfer edge
    check_value("r_valid", r_valid, 1);
    check_value("r_resp", r_resp, stim_resp[idx]);
    check_value("r_data", r_data, stim_rdata[idx]);
    data_seen = r_data;
    resp_seen = r_resp;
    draw_stall(stall);
    repeat (stall) begin
      @(negedge clk);
      #1;
      check_value("r_valid", r_valid, 1);
      check_value("r_data", r_data, data_seen);
      check_value("r_resp", r_resp, resp_seen);
    end
    @(negedge clk);
    r_ready = 1'b1;
    #1;
    check_value("r_valid", r_valid, 1);
    @(negedge clk);
    r_ready = 1'b0;
    #1;
    check_value("r_valid", r_valid, 0);
    @(negedge clk);
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    int errors_before;
    rst_n        = 1'b0;
    aw_valid     = 1'b0;
    aw_addr      = '0;
    w_valid      = 1'b0;
    w_data       = '0;
    w_strb       = '0;
    b_ready      = 1'b0;
    ar_valid     = 1'b0;
    ar_addr      = '0;
    r_ready      = 1'b0;
    error_count  = 0;
    tests_passed = 0;
    tests_failed = 0;
    b_count      = 0;
    r_count      = 0;
    b_free_q     = 1'b1;
    r_free_q     = 1'b1;
    cycle_count  = 0;
    cycle_limit  = 0;
    rng_state    = 32'hd71d_6d15;

    load_stim();
    if (n_lines == 0) begin
      $display("no transactions loaded from the stim file, run stopped");
      $display(">>> FAIL");
    end else begin
      cycle_limit = 20 * n_lines + 50;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      errors_before = error_count;
      check_value("b_valid", b_valid, 0);
      check_value("r_valid", r_valid, 0);
      check_value("aw_ready", aw_ready, 1);
      check_value("w_ready", w_ready, 1);
      check_value("ar_ready", ar_ready, 1);
      report_test("reset state", errors_before);

      for (int i = 0; i < n_lines; i++) begin
        errors_before = error_count;
        if (stim_op[i] == "W") begin
          run_write(i);
          report_test($sformatf("write %h", stim_addr[i]), errors_before);
        end else begin
          run_read(i);
          report_test($sformatf("read %h", stim_addr[i]), errors_before);
        end
      end

      // let a stray late response reach the monitor
      repeat (2) @(negedge clk);
      #2;

      // one B and one R per stim line, none lost and none extra
      errors_before = error_count;
      check_value("b responses", b_count, n_writes);
      check_value("r responses", r_count, n_reads);
      report_test("response count", errors_before);

      $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
      if (error_count == 0) begin
        $display(">>> PASS");
      end else begin
        $display(">>> FAIL");
      end
    end
    $finish;
  end

endmodule

// ==== verilog/axi_lite_bank_mem.sv ====
// ========================================
// AXI4-Lite banked memory
// slave wrapper around six memory banks
// ========================================
`timescale 1ns/1ns

module axi_lite_bank_mem (
  input  logic                    clk,
  input  logic                    rst_n,
  // AW
  input  logic                    aw_valid,
  output logic                    aw_ready,
  input  axi_lite_pkg::axi_addr_t aw_addr,
  // W
  input  logic                    w_valid,
  output logic                    w_ready,
  input  axi_lite_pkg::axi_data_t w_data,
  input  axi_lite_pkg::axi_strb_t w_strb,
  // B
  output logic                    b_valid,
  input  logic                    b_ready,
  output axi_lite_pkg::axi_resp_t b_resp,
  // AR
  input  logic                    ar_valid,
  output logic                    ar_ready,
  input  axi_lite_pkg::axi_addr_t ar_addr,
  // R
  output logic                    r_valid,
  input  logic                    r_ready,
  output axi_lite_pkg::axi_data_t r_data,
  output axi_lite_pkg::axi_resp_t r_resp
);

  bank_port_if u_bank_port (
    .clk (clk)
  );

  // write side, producer of bank writes
  axi_write_join u_write_join (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .aw_addr  (aw_addr),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .w_data   (w_data),
    .w_strb   (w_strb),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .b_resp   (b_resp),
    .bank     (u_bank_port.writer)
  );

  bank_array u_bank_array (
    .clk  (clk),
    .bank (u_bank_port.mem)
  );

  // read side
  axi_read_path u_read_path (
    .clk      (clk),
    .rst_n    (rst_n),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .ar_addr  (ar_addr),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .r_data   (r_data),
    .r_resp   (r_resp),
    .bank     (u_bank_port.reader)
  );

endmodule

// ==== verilog/axi_lite_pkg.sv ====
// ========================================
// AXI4-Lite bus types
// ========================================
`include "mem_config.svh"

package axi_lite_pkg;

  // byte address
  typedef logic [`ADDR_W-1:0] axi_addr_t;

  // one data beat
  typedef logic [`DATA_W-1:0] axi_data_t;

  // one strobe bit per byte lane
  typedef logic [`STRB_W-1:0] axi_strb_t;

  // OKAY / SLVERR
  typedef logic [1:0] axi_resp_t;

endpackage

// ==== verilog/axi_read_path.sv ====
// ========================================
// AXI4-Lite read path
// takes AR, reads the banks and returns
// data and response on R
// ========================================
`timescale 1ns/1ns
`include "mem_config.svh"

module axi_read_path (
  input  logic                    clk,
  input  logic                    rst_n,
  // AR
  input  logic                    ar_valid,
  output logic                    ar_ready,
  input  axi_lite_pkg::axi_addr_t ar_addr,
  // R
  output logic                    r_valid,
  input  logic                    r_ready,
  output axi_lite_pkg::axi_data_t r_data,
  output axi_lite_pkg::axi_resp_t r_resp,
  // bank read requests
  bank_port_if.reader             bank
);

  bank_mem_pkg::bank_sel_t ar_bank;
  bank_mem_pkg::word_idx_t ar_word;
  logic                    ar_in_range;
  logic                    ar_fire;
  logic                    rd_err_q;

  // ========================================
  // address decode and bank request
  // ========================================
  // R slot free or emptying this cycle, so reads stream
  assign ar_ready = ~r_valid | r_ready;
  assign ar_fire  = ar_valid & ar_ready;

  assign ar_bank     = ar_addr[`BANK_LSB +: `BANK_SEL_W];
  assign ar_word     = ar_addr[`WORD_LSB +: `WORD_IDX_W];
  assign ar_in_range = ar_bank < bank_mem_pkg::bank_sel_t'(`BANK_COUNT);

  assign bank.rd_en   = ar_fire & ar_in_range;
  assign bank.rd_bank = ar_bank;
  assign bank.rd_word = ar_word;

  // ========================================
  // R channel
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      r_valid  <= 1'b0;
      rd_err_q <= 1'b0;
    end else if (ar_fire) begin
      r_valid  <= 1'b1;
      rd_err_q <= ~ar_in_range;
    end else if (r_ready) begin
      r_valid <= 1'b0;
    end
  end

  // bank data holds until the next rd_en, which waits for r_ready
  assign r_data = rd_err_q ? '0 : bank.rd_data;
  assign r_resp = rd_err_q ? `RESP_SLVERR : `RESP_OKAY;

  a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
    r_valid && !r_ready |=> $stable(r_data) && $stable(r_resp));

endmodule

// ==== verilog/axi_write_join.sv ====
// ========================================
// AXI4-Lite write join
// holds AW and W separately, commits one
// bank write and answers on the B channel
// ========================================
`timescale 1ns/1ns
`include "mem_config.svh"

module axi_write_join (
  input  logic                    clk,
  input  logic                    rst_n,
  // AW
  input  logic                    aw_valid,
  output logic                    aw_ready,
  input  axi_lite_pkg::axi_addr_t aw_addr,
  // W
  input  logic                    w_valid,
  output logic                    w_ready,
  input  axi_lite_pkg::axi_data_t w_data,
  input  axi_lite_pkg::axi_strb_t w_strb,
  // B
  output logic                    b_valid,
  input  logic                    b_ready,
  output axi_lite_pkg::axi_resp_t b_resp,
  // bank write requests
  bank_port_if.writer             bank
);

  logic                    aw_held;
  logic                    w_held;
  axi_lite_pkg::axi_addr_t aw_addr_q;
  axi_lite_pkg::axi_data_t w_data_q;
  axi_lite_pkg::axi_strb_t w_strb_q;

  bank_mem_pkg::bank_sel_t wr_bank;
  bank_mem_pkg::word_idx_t wr_word;
  logic                    wr_in_range;
  logic                    commit;

  // ========================================
  // capture stages
  // ========================================
  // one slot per channel, ready drops while it is full
  assign aw_ready = ~aw_held;
  assign w_ready  = ~w_held;

  always_ff @(posedge clk) begin
    if (aw_valid && aw_ready) begin
      aw_addr_q <= aw_addr;
    end
    if (w_valid && w_ready) begin
      w_data_q <= w_data;
      w_strb_q <= w_strb;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aw_held <= 1'b0;
      w_held  <= 1'b0;
    end else begin
      if (commit) begin
        aw_held <= 1'b0;
      end else if (aw_valid && aw_ready) begin
        aw_held <= 1'b1;
      end
      if (commit) begin
        w_held <= 1'b0;
      end else if (w_valid && w_ready) begin
        w_held <= 1'b1;
      end
    end
  end

  // ========================================
  // join and commit
  // ========================================
  assign wr_bank     = aw_addr_q[`BANK_LSB +: `BANK_SEL_W];
  assign wr_word     = aw_addr_q[`WORD_LSB +: `WORD_IDX_W];
  assign wr_in_range = wr_bank < bank_mem_pkg::bank_sel_t'(`BANK_COUNT);

  // both halves present and B slot free
  assign commit = aw_held & w_held & ~b_valid;

  // out-of-range banks never reach the memory
  assign bank.wr_en   = commit & wr_in_range;
  assign bank.wr_bank = wr_bank;
  assign bank.wr_word = wr_word;
  assign bank.wr_data = w_data_q;
  assign bank.wr_strb = w_strb_q;

  // one response per committed write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      b_valid <= 1'b0;
      b_resp  <= `RESP_OKAY;
    end else if (commit) begin
      b_valid <= 1'b1;
      b_resp  <= wr_in_range ? `RESP_OKAY : `RESP_SLVERR;
    end else if (b_ready) begin
      b_valid <= 1'b0;
    end
  end

  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    b_valid && !b_ready |=> b_valid && $stable(b_resp));

  // master keeps AW steady until it is taken
  a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr));

endmodule

// ==== verilog/bank_array.sv ====
// ========================================
// banked memory
// byte-writable synchronous banks with a
// delayed read select
// ========================================
`timescale 1ns/1ns
`include "mem_config.svh"

module bank_array (
  input logic      clk,
  bank_port_if.mem bank
);

  // per-bank read registers
  axi_lite_pkg::axi_data_t bank_rd [`BANK_COUNT];
  bank_mem_pkg::bank_sel_t rd_bank_q;

  // ========================================
  // banks
  // ========================================
  for (genvar b = 0; b < `BANK_COUNT; b++) begin : g_bank
    axi_lite_pkg::axi_data_t ram [2**`WORD_IDX_W];
    logic                    wr_sel;
    logic                    rd_sel;

    assign wr_sel = bank.wr_en && (bank.wr_bank == bank_mem_pkg::bank_sel_t'(b));
    assign rd_sel = bank.rd_en && (bank.rd_bank == bank_mem_pkg::bank_sel_t'(b));

    always_ff @(posedge clk) begin
      // byte lanes under the strobes
      if (wr_sel) begin
        for (int i = 0; i < `STRB_W; i++) begin
          if (bank.wr_strb[i]) begin
            ram[bank.wr_word][8*i +: 8] <= bank.wr_data[8*i +: 8];
          end
        end
      end
      // old contents on a same-edge read and write
      if (rd_sel) begin
        bank_rd[b] <= ram[bank.rd_word];
      end
    end
  end

  // ========================================
  // read select
  // ========================================
  // bank number follows the data by one edge
  always_ff @(posedge clk) begin
    if (bank.rd_en) begin
      rd_bank_q <= bank.rd_bank;
    end
  end

  always_comb begin
    bank.rd_data = '0;
    for (int b = 0; b < `BANK_COUNT; b++) begin
      if (rd_bank_q == bank_mem_pkg::bank_sel_t'(b)) begin
        bank.rd_data = bank_rd[b];
      end
    end
  end

  // range check is done on the AXI side
  a_wr_in_range: assert property (@(posedge clk)
    bank.wr_en |-> bank.wr_bank < bank_mem_pkg::bank_sel_t'(`BANK_COUNT));

  a_rd_in_range: assert property (@(posedge clk)
    bank.rd_en |-> bank.rd_bank < bank_mem_pkg::bank_sel_t'(`BANK_COUNT));

endmodule

// ==== verilog/bank_mem_pkg.sv ====
// ========================================
// bank memory index types
// ========================================
`include "mem_config.svh"

package bank_mem_pkg;

  // bank field of the byte address
  // values at or above BANK_COUNT are not backed by memory
  typedef logic [`BANK_SEL_W-1:0] bank_sel_t;

  // word within one bank
  typedef logic [`WORD_IDX_W-1:0] word_idx_t;

endpackage

// ==== verilog/bank_port_if.sv ====
// ========================================
// bank request port
// write and read requests into the banks
// ========================================
`timescale 1ns/1ns

interface bank_port_if (
  input logic clk
);

  // write group, one-cycle pulse on wr_en
  logic                    wr_en;
  bank_mem_pkg::bank_sel_t wr_bank;
  bank_mem_pkg::word_idx_t wr_word;
  axi_lite_pkg::axi_data_t wr_data;
  axi_lite_pkg::axi_strb_t wr_strb;

  // read group, data returned after the rd_en edge
  logic                    rd_en;
  bank_mem_pkg::bank_sel_t rd_bank;
  bank_mem_pkg::word_idx_t rd_word;
  axi_lite_pkg::axi_data_t rd_data;

  modport writer (
    input  clk,
    output wr_en, wr_bank, wr_word, wr_data, wr_strb
  );

  modport reader (
    input  clk,
    output rd_en, rd_bank, rd_word,
    input  rd_data
  );

  modport mem (
    input  clk,
    input  wr_en, wr_bank, wr_word, wr_data, wr_strb,
    input  rd_en, rd_bank, rd_word,
    output rd_data
  );

endinterface

// ==== verilog/mem_config.svh ====
// ========================================
// memory and bus configuration
// widths, address fields, bank count and
// AXI response codes
// ========================================
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// bus widths
`define ADDR_W      32
`define DATA_W      32
`define STRB_W      4

// byte address fields
`define WORD_LSB    2
`define WORD_IDX_W  6
`define BANK_LSB    8
`define BANK_SEL_W  3
`define BANK_COUNT  6

`define RESP_OKAY   2'd0
`define RESP_SLVERR 2'd2

`endif
